/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation completed successfully" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
source/sched_pkg.sv
source/desc_regfile.sv
source/slot_scheduler.sv
source/block_issuer.sv
source/dma_sched_top.sv
verif/tb_model.sv
verif/tb_top.sv

/* source/block_issuer.sv */
`timescale 1ns/10ps

module block_issuer (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          issue,
  input  logic [sched_pkg::ADDR_W-1:0]  iss_addr,
  input  logic [sched_pkg::BLK_W-1:0]   iss_len,
  input  logic                          iss_dir,
  input  logic [sched_pkg::CHAN_W-1:0]  iss_chan,
  output logic                          busy,
  output logic                          done,
  output logic                          blk_req,
  input  logic                          blk_ack,
  output logic [sched_pkg::ADDR_W-1:0]  blk_addr,
  output logic [sched_pkg::BLK_W-1:0]   blk_len,
  output logic                          blk_dir,
  output logic [sched_pkg::CHAN_W-1:0]  blk_chan
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ  = 2'd1;
  localparam logic [1:0] S_REL  = 2'd2;  // mover done and waiting for ack low
  localparam logic [1:0] S_DONE = 2'd3;

  logic [1:0] state;
  logic       take;

  assign take    = (state == S_IDLE) && issue;
  assign busy    = (state != S_IDLE);
  assign done    = (state == S_DONE);
  assign blk_req = (state == S_REQ);

  // --------------------------------------------------
  // four-phase mover handshake
  // --------------------------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
      state <= S_IDLE;
    else
    begin
      case (state)
        S_IDLE:
          if (issue)
            state <= S_REQ;
        S_REQ:
          if (blk_ack)
            state <= S_REL;
        S_REL:
          if (!blk_ack)
            state <= S_DONE;
        S_DONE:
          state <= S_IDLE;
      endcase
    end
  end

  // fields stay put until the mover acks
  always_ff @(posedge CLK)
  begin
    if (take)
    begin
      blk_addr <= iss_addr;
      blk_len  <= iss_len;
      blk_dir  <= iss_dir;
      blk_chan <= iss_chan;
    end
  end

endmodule

/* source/desc_regfile.sv */
`timescale 1ns/10ps

module desc_regfile (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           cpu_req,
  input  logic                           cpu_we,
  input  logic [sched_pkg::SLOT_W-1:0]   cpu_addr,
  input  logic [sched_pkg::DATA_W-1:0]   cpu_wdata,
  output logic                           cpu_ack,
  output logic [sched_pkg::DATA_W-1:0]   cpu_rdata,
  input  logic [sched_pkg::SLOT_W-1:0]   rd_slot,
  output logic                           rd_active,
  output logic                           rd_dir,
  output logic [sched_pkg::CHAN_W-1:0]   rd_chan,
  output logic [sched_pkg::LEN_W-1:0]    rd_len,
  output logic [sched_pkg::ADDR_W-1:0]   rd_addr,
  input  logic                           wb_en,
  input  logic                           wb_active,
  input  logic [sched_pkg::SLOT_W-1:0]   wb_slot,
  input  logic [sched_pkg::LEN_W-1:0]    wb_len,
  input  logic [sched_pkg::ADDR_W-1:0]   wb_addr
);
  import sched_pkg::*;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_CONV = 2'd1;
  localparam logic [1:0] S_DO   = 2'd2;
  localparam logic [1:0] S_ACK  = 2'd3;

  logic [1:0]            state;
  logic [NUM_SLOTS-1:0]  act_q;
  logic                  dir_mem  [NUM_SLOTS];
  logic [CHAN_W-1:0]     chan_mem [NUM_SLOTS];
  logic [LEN_W-1:0]      len_mem  [NUM_SLOTS];
  logic [ADDR_W-1:0]     addr_mem [NUM_SLOTS];

  logic [BYTE_LEN_W-1:0] byte_len;
  logic [LEN_W-1:0]      word_cnt;
  logic [DATA_W-1:0]     rd_word;
  logic                  cnv_active;
  logic                  cnv_dir;
  logic [CHAN_W-1:0]     cnv_chan;
  logic [LEN_W-1:0]      cnv_len;
  logic [ADDR_W-1:0]     cnv_addr;
  logic                  cpu_wr;
  logic                  cpu_rd;

  assign byte_len = cpu_wdata[F_LEN_LO +: BYTE_LEN_W];
  assign word_cnt = LEN_W'(byte_len >> 2) + LEN_W'(byte_len[1:0] != 2'b00);  // round up

  // scheduler writeback wins and the cpu write retries next cycle
  assign cpu_wr  = (state == S_DO) && cpu_we && !wb_en;
  assign cpu_rd  = (state == S_DO) && !cpu_we;
  assign cpu_ack = (state == S_ACK);

  always_comb
  begin
    rd_word                       = '0;
    rd_word[F_ACTIVE]             = act_q[cpu_addr];
    rd_word[F_DIR]                = dir_mem[cpu_addr];
    rd_word[F_CHAN_LO +: CHAN_W]  = chan_mem[cpu_addr];
    rd_word[F_LEN_LO +: LEN_W]    = len_mem[cpu_addr];
    rd_word[F_ADDR_LO +: ADDR_W]  = addr_mem[cpu_addr];
  end

  // --------------------------------------------------
  // cpu handshake and active flags
  // --------------------------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state     <= S_IDLE;
      act_q     <= '0;
      rd_active <= 1'b0;
    end
    else
    begin
      if (wb_en)
        act_q[wb_slot] <= wb_active;
      else if (cpu_wr)
        act_q[cpu_addr] <= cnv_active;
      rd_active <= act_q[rd_slot];

      case (state)
        S_IDLE:
          if (cpu_req)
            state <= S_CONV;
        S_CONV:
          state <= S_DO;
        S_DO:
          if (cpu_wr || cpu_rd)
            state <= S_ACK;
        S_ACK:
          if (!cpu_req)
            state <= S_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // descriptor fields and read ports
  // --------------------------------------------------

  always_ff @(posedge CLK)
  begin
    if (wb_en)
    begin
      len_mem[wb_slot]  <= wb_len;
      addr_mem[wb_slot] <= wb_addr;
    end
    else if (cpu_wr)
    begin
      dir_mem[cpu_addr]  <= cnv_dir;
      chan_mem[cpu_addr] <= cnv_chan;
      len_mem[cpu_addr]  <= cnv_len;
      addr_mem[cpu_addr] <= cnv_addr;
    end

    if (state == S_CONV)
    begin
      cnv_active <= cpu_wdata[F_ACTIVE] && (word_cnt != '0);  // empty stays off
      cnv_dir    <= cpu_wdata[F_DIR];
      cnv_chan   <= cpu_wdata[F_CHAN_LO +: CHAN_W];
      cnv_len    <= word_cnt;
      cnv_addr   <= cpu_wdata[F_ADDR_LO + 2 +: ADDR_W];
    end

    if (cpu_rd)
      cpu_rdata <= rd_word;

    rd_dir  <= dir_mem[rd_slot];
    rd_chan <= chan_mem[rd_slot];
    rd_len  <= len_mem[rd_slot];
    rd_addr <= addr_mem[rd_slot];
  end

endmodule

/* source/dma_sched_top.sv */
`timescale 1ns/10ps

module dma_sched_top #(
  parameter int MAX_BLOCK  = 64,
  parameter int PAGE_WORDS = 4096
) (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            cpu_req,
  input  logic                            cpu_we,
  input  logic [sched_pkg::SLOT_W-1:0]    cpu_addr,
  input  logic [sched_pkg::DATA_W-1:0]    cpu_wdata,
  output logic                            cpu_ack,
  output logic [sched_pkg::DATA_W-1:0]    cpu_rdata,
  input  logic [sched_pkg::NUM_CHAN-1:0]  chan_ready,
  output logic                            blk_req,
  input  logic                            blk_ack,
  output logic [sched_pkg::ADDR_W-1:0]    blk_addr,
  output logic [sched_pkg::BLK_W-1:0]     blk_len,
  output logic                            blk_dir,
  output logic [sched_pkg::CHAN_W-1:0]    blk_chan,
  output logic                            irq,
  output logic [sched_pkg::SLOT_W-1:0]    irq_slot
);
  import sched_pkg::*;

  // scheduler read port
  logic [SLOT_W-1:0]  rd_slot;
  logic               rd_active;
  logic               rd_dir;
  logic [CHAN_W-1:0]  rd_chan;
  logic [LEN_W-1:0]   rd_len;
  logic [ADDR_W-1:0]  rd_addr;

  // writeback
  logic               wb_en;
  logic               wb_active;
  logic [SLOT_W-1:0]  wb_slot;
  logic [LEN_W-1:0]   wb_len;
  logic [ADDR_W-1:0]  wb_addr;

  // scheduler to issuer
  logic               issue;
  logic [ADDR_W-1:0]  iss_addr;
  logic [BLK_W-1:0]   iss_len;
  logic               iss_dir;
  logic [CHAN_W-1:0]  iss_chan;
  logic               busy;
  logic               done;

  desc_regfile regs0 (
    .CLK(CLK), .RST(RST),
    .cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
    .rd_slot(rd_slot), .rd_active(rd_active), .rd_dir(rd_dir),
    .rd_chan(rd_chan), .rd_len(rd_len), .rd_addr(rd_addr),
    .wb_en(wb_en), .wb_active(wb_active), .wb_slot(wb_slot),
    .wb_len(wb_len), .wb_addr(wb_addr)
  );

  slot_scheduler #(.MAX_BLOCK(MAX_BLOCK), .PAGE_WORDS(PAGE_WORDS)) sched0 (
    .CLK(CLK), .RST(RST),
    .rd_slot(rd_slot), .rd_active(rd_active), .rd_dir(rd_dir),
    .rd_chan(rd_chan), .rd_len(rd_len), .rd_addr(rd_addr),
    .wb_en(wb_en), .wb_slot(wb_slot), .wb_len(wb_len),
    .wb_addr(wb_addr), .wb_active(wb_active),
    .chan_ready(chan_ready),
    .issue(issue), .iss_addr(iss_addr), .iss_len(iss_len),
    .iss_dir(iss_dir), .iss_chan(iss_chan),
    .busy(busy), .done(done),
    .irq(irq), .irq_slot(irq_slot)
  );

  block_issuer issuer0 (
    .CLK(CLK), .RST(RST),
    .issue(issue), .iss_addr(iss_addr), .iss_len(iss_len),
    .iss_dir(iss_dir), .iss_chan(iss_chan),
    .busy(busy), .done(done),
    .blk_req(blk_req), .blk_ack(blk_ack),
    .blk_addr(blk_addr), .blk_len(blk_len), .blk_dir(blk_dir), .blk_chan(blk_chan)
  );

endmodule

/* source/sched_pkg.sv */
package sched_pkg;

  // --------------------------------------------------
  // descriptor slots
  // --------------------------------------------------

  localparam int NUM_SLOTS = 8;
  localparam int SLOT_W    = 3;   // slot index

  // --------------------------------------------------
  // peripheral channels
  // --------------------------------------------------

  localparam int NUM_CHAN = 4;
  localparam int CHAN_W   = 2;

  // --------------------------------------------------
  // lengths and addresses
  // --------------------------------------------------

  // byte length as the cpu writes it
  localparam int BYTE_LEN_W = 24;

  // stored remaining count in 32-bit words
  localparam int LEN_W = 22;

  // byte address without its two low bits
  localparam int ADDR_W = 30;

  localparam int BLK_W = 7;        // one block of up to 64 words

  // --------------------------------------------------
  // cpu word layout
  // --------------------------------------------------

  localparam int DATA_W = 64;

  localparam int F_ACTIVE  = 63;
  localparam int F_DIR     = 58;
  localparam int F_CHAN_LO = 56;  // CHAN_W bits up from here
  localparam int F_LEN_LO  = 32;  // byte length on write and word count on read
  localparam int F_ADDR_LO = 0;

endpackage

/* source/slot_scheduler.sv */
`timescale 1ns/10ps

module slot_scheduler #(
  parameter int MAX_BLOCK  = 64,
  parameter int PAGE_WORDS = 4096
) (
  input  logic                            CLK,
  input  logic                            RST,
  output logic [sched_pkg::SLOT_W-1:0]    rd_slot,
  input  logic                            rd_active,
  input  logic                            rd_dir,
  input  logic [sched_pkg::CHAN_W-1:0]    rd_chan,
  input  logic [sched_pkg::LEN_W-1:0]     rd_len,
  input  logic [sched_pkg::ADDR_W-1:0]    rd_addr,
  output logic                            wb_en,
  output logic [sched_pkg::SLOT_W-1:0]    wb_slot,
  output logic [sched_pkg::LEN_W-1:0]     wb_len,
  output logic [sched_pkg::ADDR_W-1:0]    wb_addr,
  output logic                            wb_active,
  input  logic [sched_pkg::NUM_CHAN-1:0]  chan_ready,
  output logic                            issue,
  output logic [sched_pkg::ADDR_W-1:0]    iss_addr,
  output logic [sched_pkg::BLK_W-1:0]     iss_len,
  output logic                            iss_dir,
  output logic [sched_pkg::CHAN_W-1:0]    iss_chan,
  input  logic                            busy,
  input  logic                            done,
  output logic                            irq,
  output logic [sched_pkg::SLOT_W-1:0]    irq_slot
);
  import sched_pkg::*;

  localparam logic S_SCAN = 1'b0;
  localparam logic S_WAIT = 1'b1;

  logic                 state;
  logic [SLOT_W-1:0]    ptr;
  logic [SLOT_W-1:0]    cur_slot;     // slot whose fields sit on rd_*
  logic                 rd_vld;
  logic [NUM_CHAN-1:0]  chan_rdy_q;

  logic [SLOT_W-1:0]    hold_slot;
  logic [LEN_W-1:0]     hold_len;
  logic [ADDR_W-1:0]    hold_addr;
  logic [BLK_W-1:0]     hold_blk;

  logic [LEN_W-1:0]     page_off;
  logic [LEN_W-1:0]     to_page;
  logic [LEN_W-1:0]     cut_a;
  logic [LEN_W-1:0]     cut;
  logic [LEN_W-1:0]     rem_len;
  logic [ADDR_W-1:0]    next_addr;
  logic                 finish;

  function automatic logic [SLOT_W-1:0] next_slot(input logic [SLOT_W-1:0] s);
    if (s == SLOT_W'(NUM_SLOTS - 1))
      return '0;
    return s + 1'b1;
  endfunction

  assign rd_slot = ptr;

  // --------------------------------------------------
  // block cut
  // --------------------------------------------------

  // words left up to the next page boundary
  assign page_off = LEN_W'(rd_addr) & LEN_W'(PAGE_WORDS - 1);
  assign to_page  = LEN_W'(PAGE_WORDS) - page_off;

  assign cut_a = (rd_len < to_page) ? rd_len : to_page;
  assign cut   = (cut_a < LEN_W'(MAX_BLOCK)) ? cut_a : LEN_W'(MAX_BLOCK);

  assign issue = (state == S_SCAN) && rd_vld && rd_active && chan_rdy_q[rd_chan] && !busy;

  assign iss_addr = rd_addr;
  assign iss_len  = BLK_W'(cut);
  assign iss_dir  = rd_dir;
  assign iss_chan = rd_chan;

  // writeback values for the block in flight
  assign rem_len   = hold_len - LEN_W'(hold_blk);
  assign next_addr = hold_addr + ADDR_W'(hold_blk);
  assign finish    = (state == S_WAIT) && done;

  // --------------------------------------------------
  // ring and in-flight control
  // --------------------------------------------------

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state      <= S_SCAN;
      ptr        <= '0;
      cur_slot   <= '0;
      rd_vld     <= 1'b0;
      chan_rdy_q <= '0;
      wb_en      <= 1'b0;
      irq        <= 1'b0;
    end
    else
    begin
      chan_rdy_q <= chan_ready;  // one flop on the way in
      wb_en      <= finish;
      irq        <= finish && (rem_len == '0);

      case (state)
        S_SCAN:
        begin
          if (issue)
          begin
            state  <= S_WAIT;
            rd_vld <= 1'b0;
          end
          else
          begin
            ptr      <= next_slot(ptr);
            cur_slot <= ptr;
            rd_vld   <= 1'b1;
          end
        end
        S_WAIT:
        begin
          if (done)
          begin
            state <= S_SCAN;
            ptr   <= next_slot(hold_slot);  // resume past this slot
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (issue)
    begin
      hold_slot <= cur_slot;
      hold_len  <= rd_len;
      hold_addr <= rd_addr;
      hold_blk  <= BLK_W'(cut);
    end

    if (finish)
    begin
      wb_slot   <= hold_slot;
      wb_len    <= rem_len;
      wb_addr   <= next_addr;
      wb_active <= (rem_len != '0);  // last block clears the slot
      irq_slot  <= hold_slot;
    end
  end

endmodule

/* verif/tb_model.sv */
`timescale 1ns/10ps

module tb_model #(
  parameter int MAX_BLOCK  = 64,
  parameter int PAGE_WORDS = 4096
) (
  input  logic                            CLK,
  input  logic                            cpu_ack,
  input  logic                            cpu_we,
  input  logic [sched_pkg::SLOT_W-1:0]    cpu_addr,
  input  logic [sched_pkg::DATA_W-1:0]    cpu_wdata,
  input  logic [sched_pkg::DATA_W-1:0]    cpu_rdata,
  input  logic [sched_pkg::NUM_CHAN-1:0]  chan_ready,
  input  logic                            blk_req,
  input  logic                            blk_ack,
  input  logic [sched_pkg::ADDR_W-1:0]    blk_addr,
  input  logic [sched_pkg::BLK_W-1:0]     blk_len,
  input  logic                            blk_dir,
  input  logic [sched_pkg::CHAN_W-1:0]    blk_chan,
  input  logic                            irq,
  input  logic [sched_pkg::SLOT_W-1:0]    irq_slot,
  output int                              irq_total,
  output logic                            check_fail
);
  import sched_pkg::*;

  // expected descriptor state per slot
  logic                 m_act   [NUM_SLOTS];
  logic                 m_dir   [NUM_SLOTS];
  logic [CHAN_W-1:0]    m_chan  [NUM_SLOTS];
  logic [LEN_W-1:0]     m_len   [NUM_SLOTS];
  logic [ADDR_W-1:0]    m_addr  [NUM_SLOTS];
  logic                 known   [NUM_SLOTS];  // written at least once
  logic                 irq_due [NUM_SLOTS];

  logic                 ack_d;
  logic                 req_d;
  logic                 blk_ack_d;
  logic                 ack_seen;
  logic [NUM_CHAN-1:0]  rdy_d1;
  logic [NUM_CHAN-1:0]  rdy_d2;
  int                   fly_slot;   // slot of the block in flight
  logic                 fly_last;

  initial
  begin
    irq_total  = 0;
    check_fail = 1'b0;
    ack_d      = 1'b0;
    req_d      = 1'b0;
    blk_ack_d  = 1'b0;
    ack_seen   = 1'b0;
    rdy_d1     = '0;
    rdy_d2     = '0;
    fly_slot   = 0;
    fly_last   = 1'b0;
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      m_act[s]   = 1'b0;
      known[s]   = 1'b0;
      irq_due[s] = 1'b0;
    end
  end

  // --------------------------------------------------
  // cpu side
  // --------------------------------------------------

  task automatic take_write();
    logic [BYTE_LEN_W-1:0] bl;
    logic [LEN_W-1:0]      words;
    bl    = cpu_wdata[F_LEN_LO +: BYTE_LEN_W];
    words = LEN_W'((int'(bl) + 3) >> 2);  // whole words rounded up
    m_act[cpu_addr]   = cpu_wdata[F_ACTIVE] && (words != '0);
    m_dir[cpu_addr]   = cpu_wdata[F_DIR];
    m_chan[cpu_addr]  = cpu_wdata[F_CHAN_LO +: CHAN_W];
    m_len[cpu_addr]   = words;
    m_addr[cpu_addr]  = cpu_wdata[F_ADDR_LO + 2 +: ADDR_W];
    known[cpu_addr]   = 1'b1;
    irq_due[cpu_addr] = 1'b0;
  endtask

  task automatic check_read();
    logic [DATA_W-1:0] exp;
    exp                          = '0;
    exp[F_ACTIVE]                = m_act[cpu_addr];
    exp[F_DIR]                   = m_dir[cpu_addr];
    exp[F_CHAN_LO +: CHAN_W]     = m_chan[cpu_addr];
    exp[F_LEN_LO +: LEN_W]       = m_len[cpu_addr];
    exp[F_ADDR_LO +: ADDR_W]     = m_addr[cpu_addr];
    if (!known[cpu_addr])
    begin
      assert (cpu_rdata[F_ACTIVE] == 1'b0)
      else
      begin
        $display("mismatch cpu_rdata active slot %0d: got %h expected 0",
                 cpu_addr, cpu_rdata[F_ACTIVE]);
        check_fail = 1'b1;
      end
    end
    else
    begin
      assert (cpu_rdata == exp)
      else
      begin
        $display("mismatch cpu_rdata slot %0d: got %h expected %h", cpu_addr, cpu_rdata, exp);
        check_fail = 1'b1;
      end
    end
  endtask

  // --------------------------------------------------
  // block side
  // --------------------------------------------------

  task automatic check_block();
    int hit;
    int want;
    int to_page;
    hit      = -1;
    fly_last = 1'b0;
    for (int s = 0; s < NUM_SLOTS; s++)
      if (hit < 0 && m_act[s] && m_addr[s] == blk_addr)
        hit = s;
    assert (hit >= 0)
    else
    begin
      $display("block at word address %h continues no active descriptor", blk_addr);
      check_fail = 1'b1;
    end
    if (hit >= 0)
    begin
      want    = int'(m_len[hit]);
      to_page = PAGE_WORDS - (int'(m_addr[hit]) % PAGE_WORDS);
      if (want > MAX_BLOCK)
        want = MAX_BLOCK;
      if (want > to_page)
        want = to_page;
      assert (blk_len == BLK_W'(want) && blk_dir == m_dir[hit] && blk_chan == m_chan[hit])
      else
      begin
        $display("mismatch blk_len/blk_dir/blk_chan slot %0d: got %h/%h/%h expected %h/%h/%h",
                 hit, blk_len, blk_dir, blk_chan, BLK_W'(want), m_dir[hit], m_chan[hit]);
        check_fail = 1'b1;
      end
      assert (rdy_d1[blk_chan] || rdy_d2[blk_chan])
      else
      begin
        $display("block for channel %0d started after two cycles of chan_ready low", blk_chan);
        check_fail = 1'b1;
      end
      m_len[hit]  = m_len[hit] - LEN_W'(want);
      m_addr[hit] = m_addr[hit] + ADDR_W'(want);
      if (m_len[hit] == '0)
      begin
        m_act[hit] = 1'b0;
        fly_slot   = hit;
        fly_last   = 1'b1;  // last block of this descriptor
      end
    end
  endtask

  // all ports are sampled half a cycle away from the driving edge
  always @(negedge CLK)
  begin
    if (cpu_ack && !ack_d)
    begin
      if (cpu_we)
        take_write();
      else
        check_read();
    end

    if (blk_req && !req_d)
      check_block();
    if (blk_req && blk_ack)
      ack_seen = 1'b1;
    if (req_d && !blk_req)
    begin
      assert (ack_seen)
      else
      begin
        $display("blk_req dropped before the mover raised blk_ack");
        check_fail = 1'b1;
      end
      ack_seen = 1'b0;
    end
    if (blk_ack_d && !blk_ack && fly_last)
    begin
      irq_due[fly_slot] = 1'b1;  // handshake of the last block is over
      fly_last          = 1'b0;
    end

    if (irq)
    begin
      assert (irq_due[irq_slot])
      else
      begin
        $display("irq for slot %0d without a finished descriptor", irq_slot);
        check_fail = 1'b1;
      end
      irq_due[irq_slot] = 1'b0;
      irq_total++;
    end

    ack_d     = cpu_ack;
    req_d     = blk_req;
    blk_ack_d = blk_ack;
    rdy_d2    = rdy_d1;
    rdy_d1    = chan_ready;
  end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/10ps

module tb_top;
  import sched_pkg::*;

  localparam int MAX_BLOCK  = 64;
  localparam int PAGE_WORDS = 4096;
  localparam int ROUNDS     = 4;
  localparam int ACK_MAX    = 7;
  localparam int MAX_WORDS  = 256;  // 10-bit byte lengths
  localparam int TIMEOUT    = 2000
                            + ROUNDS * NUM_SLOTS * MAX_WORDS * (ACK_MAX + NUM_SLOTS + 8) * 4;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                 CLK;
  logic                 RST;
  logic                 cpu_req;
  logic                 cpu_we;
  logic [SLOT_W-1:0]    cpu_addr;
  logic [DATA_W-1:0]    cpu_wdata;
  logic                 cpu_ack;
  logic [DATA_W-1:0]    cpu_rdata;
  logic [NUM_CHAN-1:0]  chan_ready;
  logic                 blk_req;
  logic                 blk_ack;
  logic [ADDR_W-1:0]    blk_addr;
  logic [BLK_W-1:0]     blk_len;
  logic                 blk_dir;
  logic [CHAN_W-1:0]    blk_chan;
  logic                 irq;
  logic [SLOT_W-1:0]    irq_slot;

  int                   irq_total;
  logic                 check_fail;
  logic                 own_fail  = 1'b0;
  logic                 timed_out = 1'b0;
  logic                 run_en    = 1'b0;
  logic                 ack_armed = 1'b0;
  int                   ack_wait  = 0;
  int                   want_irq  = 0;
  int                   cycles    = 0;
  logic [31:0]          lfsr_state = 32'd97637;

  dma_sched_top #(.MAX_BLOCK(MAX_BLOCK), .PAGE_WORDS(PAGE_WORDS)) dut0 (.*);

  tb_model #(.MAX_BLOCK(MAX_BLOCK), .PAGE_WORDS(PAGE_WORDS)) model0 (.*);

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // one lfsr step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb)
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  task automatic step_clock();
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_ack(input logic level);
    do
      step_clock();
    while (cpu_ack != level);
  endtask

  task automatic cpu_access(input logic we, input int slot, input logic [DATA_W-1:0] data);
    cpu_we    = we;
    cpu_addr  = SLOT_W'(slot);
    cpu_wdata = data;
    cpu_req   = 1'b1;
    wait_ack(1'b1);
    cpu_req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic expect_low(input string name, input logic value);
    assert (value == 1'b0)
    else
    begin
      $display("mismatch %s: got %h expected 0", name, value);
      own_fail = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // channel readiness and block mover
  // --------------------------------------------------

  always @(posedge CLK)
  begin : drive_env
    logic [31:0] flip;
    logic        en;
    en = run_en;  // run_en as it stood at the edge
    #2;
    if (!en)
      chan_ready = '0;
    else if (lfsr_bits(3) == 0)
    begin
      flip = lfsr_bits(CHAN_W);
      chan_ready[flip[CHAN_W-1:0]] = !chan_ready[flip[CHAN_W-1:0]];
    end

    if (blk_ack)
    begin
      if (!blk_req)
        blk_ack = 1'b0;
    end
    else if (blk_req)
    begin
      if (!ack_armed)
      begin
        ack_wait  = int'(lfsr_bits(3));  // 0 to ACK_MAX cycles
        ack_armed = 1'b1;
      end
      if (ack_wait == 0)
      begin
        blk_ack   = 1'b1;
        ack_armed = 1'b0;
      end
      else
        ack_wait--;
    end
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles == TIMEOUT)
    begin
      $display("timeout: descriptors not finished within %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  end

  always @(check_fail or own_fail or timed_out)
  begin
    if (check_fail || own_fail || timed_out)
    begin
      $display("Simulation failed");
      $fatal(1, "run stopped on the first error");
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial
  begin : main
    logic [DATA_W-1:0]     word;
    logic [BYTE_LEN_W-1:0] blen;
    logic [31:0]           baddr;
    logic [31:0]           rnd;
    logic                  act;
    RST        = 1'b0;
    cpu_req    = 1'b0;
    cpu_we     = 1'b0;
    cpu_addr   = '0;
    cpu_wdata  = '0;
    chan_ready = '0;
    blk_ack    = 1'b0;
    repeat (16) @(posedge CLK);
    #2;
    RST = 1'b1;
    step_clock();
    expect_low("cpu_ack", cpu_ack);
    expect_low("blk_req", blk_req);
    expect_low("irq", irq);
    for (int s = 0; s < NUM_SLOTS; s++)
      cpu_access(1'b0, s, '0);

    for (int r = 0; r < ROUNDS; r++)
    begin
      for (int s = 0; s < NUM_SLOTS; s++)
      begin
        act  = (lfsr_bits(3) != 0);
        blen = (lfsr_bits(3) == 0) ? '0 : BYTE_LEN_W'(lfsr_bits(10));
        // each slot gets its own page and starts a little before its end
        rnd   = (lfsr_bits(5) << 3) | 32'(s);
        baddr = (rnd + 32'd1) << 14;
        baddr = baddr - lfsr_bits(9);
        rnd   = lfsr_bits(1);
        word                           = '0;
        word[F_ACTIVE]                 = act;
        word[F_ACTIVE-1:F_DIR+1]       = 4'(lfsr_bits(4));  // unused bits
        word[F_DIR]                    = rnd[0];
        word[F_CHAN_LO +: CHAN_W]      = CHAN_W'(lfsr_bits(CHAN_W));
        word[F_LEN_LO +: BYTE_LEN_W]   = blen;
        word[31:0]                     = baddr;
        if (act && blen != '0)
          want_irq++;
        cpu_access(1'b1, s, word);
      end
      for (int s = 0; s < NUM_SLOTS; s++)
        cpu_access(1'b0, s, '0);

      run_en = 1'b1;
      do
        step_clock();
      while (irq_total != want_irq);
      run_en = 1'b0;
      repeat (4) step_clock();
      for (int s = 0; s < NUM_SLOTS; s++)
        cpu_access(1'b0, s, '0);
    end

    if (check_fail || own_fail)
    begin
      $display("Simulation failed");
      $fatal(1, "checks failed");
    end
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
